// ==== sim/rv_core_golden.txt ====
// columns: instruction word, write flag (1 = write, 0 = none), rd, expected rd value
// one line per instruction in stream order, the pc is 4 times the line position
00500093 1 01 0000000000000005 // addi x1, x0, 5
ffd08113 1 02 0000000000000002 // addi x2, x1, -3
401101b3 1 03 fffffffffffffffd // sub x3, x2, x1
0011a233 1 04 0000000000000001 // slt x4, x3, x1
0011b2b3 1 05 0000000000000000 // sltu x5, x3, x1
03f09313 1 06 8000000000000000 // slli x6, x1, 63
43f35393 1 07 ffffffffffffffff // srai x7, x6, 63
03f35413 1 08 0000000000000001 // srli x8, x6, 63
fff0c493 1 09 fffffffffffffffa // xori x9, x1, -1
0020e533 1 0a 0000000000000007 // or x10, x1, x2
00a4f5b3 1 0b 0000000000000002 // and x11, x9, x10
80000637 1 0c ffffffff80000000 // lui x12, 0x80000
fff6069b 1 0d 000000007fffffff // addiw x13, x12, -1
0016873b 1 0e ffffffff80000004 // addw x14, x13, x1
007097bb 1 0f ffffffff80000000 // sllw x15, x1, x7
4047581b 1 10 fffffffff8000000 // sraiw x16, x14, 4
0047589b 1 11 0000000008000000 // srliw x17, x14, 4
12345917 1 12 0000000012345044 // auipc x18, 0x12345 at pc 0x44
0000b983 0 00 0000000000000000 // ld x19, 0(x1), not supported
00708013 0 00 0000000000000000 // addi x0, x1, 7
00100a33 1 14 0000000000000005 // add x20, x0, x1
0019ba93 1 15 0000000000000001 // sltiu x21, x19, 1
ffe1ab13 1 16 0000000000000001 // slti x22, x3, -2
40160bbb 1 17 000000007ffffffb // subw x23, x12, x1
40165c33 1 18 fffffffffc000000 // sra x24, x12, x1

// ==== vlog.f ====
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/ins_accept.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/rv_core.sv
sim/wb_checker.sv
sim/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run the testbench and look for the pass line in the log
rm -f sim.log
verilator --binary --timescale 1ns/10ps --top-module tb_rv_core -f vlog.f -o sim_rv_core \
    && ./obj_dir/sim_rv_core 2>&1 | tee sim.log \
    || { echo "simulation build or run failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// ==== sim/tb_rv_core.sv ====
// testbench top that reads the golden stream, feeds the instruction port and reports the result
`timescale 1ns/10ps

`include "rv_core_settings.svh"

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int    CLK_HALF     = 4;
    localparam int    RST_CYC      = 4;
    localparam int    MAX_INS      = 64;
    localparam int    DRAIN_CYC    = 4;
    localparam int    ACK_HOLD_CYC = 2;
    localparam int    WDOG_PER_INS = 10;
    localparam int    WDOG_MARGIN  = 50;
    localparam string GOLDEN_FILE  = "sim/rv_core_golden.txt";

    logic     c_clk;
    logic     c_rst_n;
    logic     ins_req;
    instr_t   ins;
    logic     ins_ack;
    logic     wb_valid;
    reg_idx_t wb_rd;
    xlen_t    wb_data;

    // four words per golden line
    logic [`RV_XLEN-1:0] gold_mem [4*MAX_INS];
    instr_t   ins_list [MAX_INS];
    reg_idx_t exp_rd [MAX_INS];
    xlen_t    exp_data [MAX_INS];
    int       n_ins;
    int       n_exp;
    int       err_cnt;
    int       wr_cnt;
    logic     loaded;

    rv_core i_dut (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .ins_req_i  (ins_req),
        .ins_i      (ins),
        .ins_ack_o  (ins_ack),
        .wb_valid_o (wb_valid),
        .wb_rd_o    (wb_rd),
        .wb_data_o  (wb_data)
    );

    wb_checker #(
        .MAX_WR (MAX_INS)
    ) u_checker (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .ins_req_i  (ins_req),
        .ins_ack_i  (ins_ack),
        .wb_valid_i (wb_valid),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data),
        .exp_rd_i   (exp_rd),
        .exp_data_i (exp_data),
        .exp_cnt_i  (n_exp),
        .err_cnt_o  (err_cnt),
        .wr_cnt_o   (wr_cnt)
    );

    initial begin
        c_clk = 1'b0;
    end

    always #CLK_HALF c_clk = ~c_clk;

    task automatic load_golden();
        int i;
        // unread slots keep ones above the instruction bits
        for (i = 0; i < 4*MAX_INS; i++) begin
            gold_mem[i] = ~xlen_t'(i);
        end
        $readmemh(GOLDEN_FILE, gold_mem);
        n_ins = 0;
        n_exp = 0;
        for (i = 0; i < MAX_INS; i++) begin
            if (gold_mem[4*i][`RV_XLEN-1:`RV_ILEN] != '0) begin
                break;
            end
            ins_list[n_ins] = gold_mem[4*i][`RV_ILEN-1:0];
            if (gold_mem[4*i+1] != '0) begin
                exp_rd[n_exp]   = gold_mem[4*i+2][`RV_REG_AW-1:0];
                exp_data[n_exp] = gold_mem[4*i+3];
                n_exp++;
            end
            n_ins++;
        end
    endtask

    // one full four-phase cycle entered and left 1 ns after a rising edge
    task automatic send_ins(input instr_t word, input int hold_cyc);
        ins_req = 1'b1;
        ins     = word;
        do begin
            @(posedge c_clk);
            #1;
        end while (!ins_ack);
        // req may stay up a while, ack has to wait for it
        if (hold_cyc > 0) begin
            repeat (hold_cyc) @(posedge c_clk);
            #1;
        end
        ins_req = 1'b0;
        do begin
            @(posedge c_clk);
            #1;
        end while (ins_ack);
    endtask

    initial begin
        c_rst_n = 1'b0;
        ins_req = 1'b0;
        ins     = `RV_NOP;
        loaded  = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (RST_CYC) @(posedge c_clk);
        #1;
        c_rst_n = 1'b1;
        // quiet port first with no ack and no writeback expected
        repeat (3) @(posedge c_clk);
        #1;
        // only the last word holds req, so no forwarding case is lost
        for (int k = 0; k < n_ins; k++) begin
            send_ins(ins_list[k], (k == n_ins - 1) ? ACK_HOLD_CYC : 0);
        end
        // two edges of latency after the last accept
        repeat (DRAIN_CYC) @(posedge c_clk);
        #1;
        if (n_ins == 0) begin
            $display("no instructions were read from %s", GOLDEN_FILE);
        end
        if (wr_cnt < n_exp) begin
            $display("%0d expected writebacks never arrived", n_exp - wr_cnt);
        end
        $display("errors: %0d, writebacks seen: %0d of %0d expected", err_cnt, wr_cnt, n_exp);
        if (err_cnt == 0 && wr_cnt == n_exp && n_ins > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog scaled to the stream length
    initial begin
        wait (loaded);
        repeat (n_ins * WDOG_PER_INS + WDOG_MARGIN) @(posedge c_clk);
        $display("timeout at %0t: the instruction stream did not complete in %0d cycles",
                 $time, n_ins * WDOG_PER_INS + WDOG_MARGIN);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sim/wb_checker.sv ====
// testbench monitor: checks the instruction handshake and compares each writeback with the list
`timescale 1ns/10ps

module wb_checker #(
    parameter int MAX_WR = 64
) (
    input  logic                  c_clk,
    input  logic                  c_rst_n,
    input  logic                  ins_req_i,
    input  logic                  ins_ack_i,
    input  logic                  wb_valid_i,
    input  rv_core_pkg::reg_idx_t wb_rd_i,
    input  rv_core_pkg::xlen_t    wb_data_i,
    input  rv_core_pkg::reg_idx_t exp_rd_i [MAX_WR],
    input  rv_core_pkg::xlen_t    exp_data_i [MAX_WR],
    input  int                    exp_cnt_i,
    output int                    err_cnt_o,
    output int                    wr_cnt_o
);
    import rv_core_pkg::*;

    logic req_q;
    logic ack_q;

    // sampled mid-cycle, the DUT only changes on the rising edge
    always @(negedge c_clk) begin
        if (!c_rst_n) begin
            req_q     = 1'b0;
            ack_q     = 1'b0;
            err_cnt_o = 0;
            wr_cnt_o  = 0;
        end else begin
            if (ins_ack_i && !ack_q && !req_q) begin
                $display("handshake fault at %0t: ack rose with no request pending", $time);
                err_cnt_o = err_cnt_o + 1;
            end
            if (!ins_ack_i && ack_q && req_q) begin
                $display("handshake fault at %0t: ack fell while the request was high", $time);
                err_cnt_o = err_cnt_o + 1;
            end
            if (wb_valid_i) begin
                if (wr_cnt_o >= exp_cnt_i) begin
                    $display("unexpected writeback at %0t to x%0d", $time, wb_rd_i);
                    err_cnt_o = err_cnt_o + 1;
                end else if (wb_rd_i !== exp_rd_i[wr_cnt_o]
                             || wb_data_i !== exp_data_i[wr_cnt_o]) begin
                    $display("error at %0t: write %0d expected x%0d = %h, got x%0d = %h",
                             $time, wr_cnt_o, exp_rd_i[wr_cnt_o], exp_data_i[wr_cnt_o],
                             wb_rd_i, wb_data_i);
                    err_cnt_o = err_cnt_o + 1;
                end
                wr_cnt_o = wr_cnt_o + 1;
            end
            req_q = ins_req_i;
            ack_q = ins_ack_i;
        end
    end

endmodule

// ==== hdl/rv_core.sv ====
// top level of the three-stage core, instruction port in and writeback ports out
`timescale 1ns/10ps

module rv_core (
    input  logic                  c_clk,
    input  logic                  c_rst_n,
    input  logic                  ins_req_i,
    input  rv_core_pkg::instr_t   ins_i,
    output logic                  ins_ack_o,
    output logic                  wb_valid_o,
    output rv_core_pkg::reg_idx_t wb_rd_o,
    output rv_core_pkg::xlen_t    wb_data_o
);
    import rv_core_pkg::*;

    logic     f_valid;
    instr_t   f_ins;
    xlen_t    f_pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    logic     x_valid;
    instr_t   x_ins;
    xlen_t    x_a;
    xlen_t    x_b;

    ins_accept u_ins_accept (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .ins_req_i  (ins_req_i),
        .ins_i      (ins_i),
        .ins_ack_o  (ins_ack_o),
        .f_valid_o  (f_valid),
        .f_ins_o    (f_ins),
        .f_pc_o     (f_pc)
    );

    // x_pc stays inside decode for tracing only
    decode_stage u_decode (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .f_valid_i  (f_valid),
        .f_ins_i    (f_ins),
        .f_pc_i     (f_pc),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .wb_valid_i (wb_valid_o),
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o),
        .x_valid_o  (x_valid),
        .x_ins_o    (x_ins),
        .x_pc_o     (),
        .x_a_o      (x_a),
        .x_b_o      (x_b)
    );

    regfile u_regfile (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_valid_o),
        .rd_i       (wb_rd_o),
        .rd_data_i  (wb_data_o)
    );

    execute_stage u_execute (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .x_valid_i  (x_valid),
        .x_ins_i    (x_ins),
        .x_a_i      (x_a),
        .x_b_i      (x_b),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

// ==== hdl/execute_stage.sv ====
// execute stage: RV64I ALU including W forms, and the EX/WB register driving writeback
`timescale 1ns/10ps

`include "rv_core_settings.svh"

module execute_stage (
    input  logic                  c_clk,
    input  logic                  c_rst_n,
    input  logic                  x_valid_i,
    input  rv_core_pkg::instr_t   x_ins_i,
    input  rv_core_pkg::xlen_t    x_a_i,
    input  rv_core_pkg::xlen_t    x_b_i,
    output logic                  wb_valid_o,
    output rv_core_pkg::reg_idx_t wb_rd_o,
    output rv_core_pkg::xlen_t    wb_data_o
);
    import rv_core_pkg::*;

    opcode_t  opcode;
    reg_idx_t rd;
    logic     is_w;
    logic     is_rr;
    logic     is_upper;
    logic [2:0] funct3;
    logic [5:0] shamt;
    xlen_t    srl_src;
    xlen_t    sra_src;
    xlen_t    alu_res;
    xlen_t    result;

    assign opcode   = x_ins_i[6:0];
    assign rd       = x_ins_i[11:7];
    assign is_w     = (opcode == `RV_OP_ALRIW) || (opcode == `RV_OP_ALRRW);
    assign is_rr    = (opcode == `RV_OP_ALRR) || (opcode == `RV_OP_ALRRW);
    assign is_upper = (opcode == `RV_OP_LUI) || (opcode == `RV_OP_AUIPC);

    // lui/auipc carry immediate bits in funct3, force an add
    assign funct3 = is_upper ? 3'b000 : x_ins_i[14:12];
    assign shamt  = is_w ? {1'b0, x_b_i[4:0]} : x_b_i[5:0];

    // right shifts on W forms see only the low word
    assign srl_src = is_w ? {32'b0, x_a_i[31:0]} : x_a_i;
    assign sra_src = is_w ? {{32{x_a_i[31]}}, x_a_i[31:0]} : x_a_i;

    always_comb begin
        case (funct3)
            3'b000: alu_res = (is_rr && x_ins_i[30]) ? x_a_i - x_b_i : x_a_i + x_b_i;
            3'b001: alu_res = x_a_i << shamt;
            3'b010: alu_res = xlen_t'($signed(x_a_i) < $signed(x_b_i));
            3'b011: alu_res = xlen_t'(x_a_i < x_b_i);
            3'b100: alu_res = x_a_i ^ x_b_i;
            3'b101: begin
                if (x_ins_i[30]) begin
                    alu_res = xlen_t'($signed(sra_src) >>> shamt);
                end else begin
                    alu_res = srl_src >> shamt;
                end
            end
            3'b110: alu_res = x_a_i | x_b_i;
            default: alu_res = x_a_i & x_b_i;
        endcase
    end

    assign result = is_w ? {{32{alu_res[31]}}, alu_res[31:0]} : alu_res;

    // writes to x0 are dropped here
    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            wb_valid_o <= 1'b0;
            wb_rd_o    <= '0;
        end else begin
            wb_valid_o <= x_valid_i && (rd != '0);
            wb_rd_o    <= rd;
        end
    end

    always_ff @(posedge c_clk) begin
        wb_data_o <= result;
    end

endmodule

// ==== hdl/decode_stage.sv ====
// decode stage: operand read with writeback forwarding, immediates and the ID/EX register
`timescale 1ns/10ps

`include "rv_core_settings.svh"

module decode_stage (
    input  logic                  c_clk,
    input  logic                  c_rst_n,
    input  logic                  f_valid_i,
    input  rv_core_pkg::instr_t   f_ins_i,
    input  rv_core_pkg::xlen_t    f_pc_i,
    output rv_core_pkg::reg_idx_t rs1_o,
    output rv_core_pkg::reg_idx_t rs2_o,
    input  rv_core_pkg::xlen_t    rs1_data_i,
    input  rv_core_pkg::xlen_t    rs2_data_i,
    input  logic                  wb_valid_i,
    input  rv_core_pkg::reg_idx_t wb_rd_i,
    input  rv_core_pkg::xlen_t    wb_data_i,
    output logic                  x_valid_o,
    output rv_core_pkg::instr_t   x_ins_o,
    output rv_core_pkg::xlen_t    x_pc_o,
    output rv_core_pkg::xlen_t    x_a_o,
    output rv_core_pkg::xlen_t    x_b_o
);
    import rv_core_pkg::*;

    opcode_t opcode;
    logic    supported;
    logic    is_rr;
    logic    is_upper;
    xlen_t   rs1_val;
    xlen_t   rs2_val;
    xlen_t   imm_i;
    xlen_t   imm_u;
    xlen_t   op_a;
    xlen_t   op_b;

    assign opcode = f_ins_i[6:0];
    assign rs1_o  = f_ins_i[19:15];
    assign rs2_o  = f_ins_i[24:20];

    assign is_rr    = (opcode == `RV_OP_ALRR) || (opcode == `RV_OP_ALRRW);
    assign is_upper = (opcode == `RV_OP_LUI) || (opcode == `RV_OP_AUIPC);
    assign supported = is_rr || is_upper
                     || (opcode == `RV_OP_ALRI) || (opcode == `RV_OP_ALRIW);

    // previous result not yet in the register file
    assign rs1_val = (wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == rs1_o))
                   ? wb_data_i : rs1_data_i;
    assign rs2_val = (wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == rs2_o))
                   ? wb_data_i : rs2_data_i;

    assign imm_i = {{52{f_ins_i[31]}}, f_ins_i[31:20]};
    assign imm_u = {{32{f_ins_i[31]}}, f_ins_i[31:12], 12'b0};

    assign op_a = (opcode == `RV_OP_AUIPC) ? f_pc_i
                : (opcode == `RV_OP_LUI)   ? '0
                : rs1_val;
    assign op_b = is_rr ? rs2_val : (is_upper ? imm_u : imm_i);

    // unsupported words become bubbles
    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            x_valid_o <= 1'b0;
            x_ins_o   <= `RV_NOP;
        end else begin
            x_valid_o <= f_valid_i && supported;
            x_ins_o   <= f_valid_i ? f_ins_i : `RV_NOP;
        end
    end

    always_ff @(posedge c_clk) begin
        x_pc_o <= f_pc_i;
        x_a_o  <= op_a;
        x_b_o  <= op_b;
    end

endmodule

// ==== hdl/regfile.sv ====
// integer register file, two combinational read ports and one synchronous write port
`timescale 1ns/10ps

`include "rv_core_settings.svh"

module regfile (
    input  logic                  c_clk,
    input  logic                  c_rst_n,
    input  rv_core_pkg::reg_idx_t rs1_i,
    input  rv_core_pkg::reg_idx_t rs2_i,
    output rv_core_pkg::xlen_t    rs1_data_o,
    output rv_core_pkg::xlen_t    rs2_data_o,
    input  logic                  we_i,
    input  rv_core_pkg::reg_idx_t rd_i,
    input  rv_core_pkg::xlen_t    rd_data_i
);
    import rv_core_pkg::*;

    xlen_t regs [`RV_REG_CNT];

    // x0 always reads as zero
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            for (int i = 0; i < `RV_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= rd_data_i;
        end
    end

endmodule

// ==== hdl/ins_accept.sv ====
// instruction port with four-phase req/ack, pc counter and fetch register for decode
`timescale 1ns/10ps

`include "rv_core_settings.svh"

module ins_accept (
    input  logic                 c_clk,
    input  logic                 c_rst_n,
    input  logic                 ins_req_i,
    input  rv_core_pkg::instr_t  ins_i,
    output logic                 ins_ack_o,
    output logic                 f_valid_o,
    output rv_core_pkg::instr_t  f_ins_o,
    output rv_core_pkg::xlen_t   f_pc_o
);
    import rv_core_pkg::*;

    accept_state_t state;
    xlen_t         pc;
    logic          accept;

    // new word only when the previous handshake has closed
    assign accept    = (state == IDLE) && ins_req_i;
    assign ins_ack_o = (state == ACKED);

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            state     <= IDLE;
            pc        <= '0;
            f_valid_o <= 1'b0;
            f_ins_o   <= `RV_NOP;
            f_pc_o    <= '0;
        end else begin
            f_valid_o <= accept;
            case (state)
                IDLE: begin
                    if (ins_req_i) begin
                        state   <= ACKED;
                        f_ins_o <= ins_i;
                        f_pc_o  <= pc;
                        pc      <= pc + xlen_t'(`RV_PC_STEP);
                    end
                end
                // hold ack until the source drops req
                ACKED: begin
                    if (!ins_req_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/rv_core_pkg.sv ====
// shared types of the core, imported by every RTL module and the testbench
package rv_core_pkg;

`include "rv_core_settings.svh"

    // data word and instruction word
    typedef logic [`RV_XLEN-1:0] xlen_t;
    typedef logic [`RV_ILEN-1:0] instr_t;

    // register index, rs1/rs2/rd
    typedef logic [`RV_REG_AW-1:0] reg_idx_t;

    typedef logic [6:0] opcode_t;

    // four-phase handshake on the instruction port
    typedef enum logic {
        IDLE,
        ACKED
    } accept_state_t;

endpackage

// ==== hdl/rv_core_settings.svh ====
// core-wide widths, opcodes and constants, included by the RTL and the testbench
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

`define RV_XLEN     64
`define RV_ILEN     32
`define RV_REG_CNT  32
`define RV_REG_AW   5

// major opcodes handled by the core
`define RV_OP_ALRI  7'b0010011
`define RV_OP_ALRIW 7'b0011011
`define RV_OP_ALRR  7'b0110011
`define RV_OP_ALRRW 7'b0111011
`define RV_OP_LUI   7'b0110111
`define RV_OP_AUIPC 7'b0010111

// addi x0, x0, 0
`define RV_NOP      32'h0000_0013
`define RV_PC_STEP  4

`endif
